//--- alu/alu_arith.sv
`timescale 1ns/1ns

module alu_arith
    import mips_isa_pkg::*, exec_types_pkg::*;
(
    input  ex_issue_t issue,
    output word_t     arith_res,
    output logic      ov_sum
);

    logic       sub_sel;
    word_t      reg2_mux;
    word_t      sum;
    logic       sum_ov;
    logic       lt;
    word_t      lead_src;
    logic [5:0] lead_cnt;

    // slt reuses the subtractor to get the signed compare
    assign sub_sel  = (issue.aluop == OP_SUB) || (issue.aluop == OP_SUBU) ||
                      (issue.aluop == OP_SLT);
    assign reg2_mux = sub_sel ? (~issue.reg2 + 1'b1) : issue.reg2;
    assign sum      = issue.reg1 + reg2_mux;

    assign sum_ov = (!issue.reg1[WORD_W-1] && !reg2_mux[WORD_W-1] && sum[WORD_W-1]) ||
                    (issue.reg1[WORD_W-1] && reg2_mux[WORD_W-1] && !sum[WORD_W-1]);

    // only the trapping forms raise the exception
    assign ov_sum = sum_ov && ((issue.aluop == OP_ADD) || (issue.aluop == OP_ADDI) ||
                               (issue.aluop == OP_SUB));

    assign lt = (issue.aluop == OP_SLT) ?
                ((issue.reg1[WORD_W-1] && !issue.reg2[WORD_W-1]) ||
                 (!issue.reg1[WORD_W-1] && !issue.reg2[WORD_W-1] && sum[WORD_W-1]) ||
                 (issue.reg1[WORD_W-1] && issue.reg2[WORD_W-1] && sum[WORD_W-1])) :
                (issue.reg1 < issue.reg2);

    // clo is clz on the inverted word
    assign lead_src = (issue.aluop == OP_CLO) ? ~issue.reg1 : issue.reg1;

    always_comb begin
        lead_cnt = 6'd32;
        for (int i = 0; i < WORD_W; i++) begin
            if (lead_src[i]) begin
                lead_cnt = 6'(WORD_W - 1 - i); // highest set bit wins
            end
        end
    end

    always_comb begin
        case (issue.aluop)
            OP_SLT, OP_SLTU: begin
                arith_res = word_t'(lt);
            end
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU: begin
                arith_res = sum;
            end
            OP_CLZ, OP_CLO: begin
                arith_res = word_t'(lead_cnt);
            end
            default: begin
                arith_res = '0;
            end
        endcase
    end

endmodule

//--- alu/alu_logic_shift.sv
`timescale 1ns/1ns

module alu_logic_shift
    import mips_isa_pkg::*, exec_types_pkg::*;
(
    input  ex_issue_t issue,
    output word_t     logic_res,
    output word_t     shift_res
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = issue.reg1[SHAMT_W-1:0]; // shift amount comes in on reg1

    always_comb begin
        case (issue.aluop)
            OP_OR: begin
                logic_res = issue.reg1 | issue.reg2;
            end
            OP_AND: begin
                logic_res = issue.reg1 & issue.reg2;
            end
            OP_NOR: begin
                logic_res = ~(issue.reg1 | issue.reg2);
            end
            OP_XOR: begin
                logic_res = issue.reg1 ^ issue.reg2;
            end
            default: begin
                logic_res = '0;
            end
        endcase
    end

    always_comb begin
        case (issue.aluop)
            OP_SLL: begin
                shift_res = issue.reg2 << shamt;
            end
            OP_SRL: begin
                shift_res = issue.reg2 >> shamt;
            end
            OP_SRA: begin
                shift_res = word_t'($signed(issue.reg2) >>> shamt); // sign fill
            end
            default: begin
                shift_res = '0;
            end
        endcase
    end

endmodule

//--- common/exec_types_pkg.sv
package exec_types_pkg;

    import mips_isa_pkg::*;

    // one decoded operation handed to the execute stage
    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;   // destination register
        logic      wreg; // write request from decode
    } ex_issue_t;

    // register write-back leaving the stage
    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;  // final write enable
        word_t     wdata;
        logic      ov;    // signed overflow exception
    } ex_wb_t;

endpackage

//--- common/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // codes follow the SPECIAL funct field where one exists
    typedef enum logic [5:0] {
        OP_SLL   = 6'h00,
        OP_SRL   = 6'h02,
        OP_SRA   = 6'h03,
        OP_ADDI  = 6'h08, // immediate forms reuse free funct slots
        OP_ADDIU = 6'h09,
        OP_MOVZ  = 6'h0a,
        OP_MOVN  = 6'h0b,
        OP_MFHI  = 6'h10,
        OP_MTHI  = 6'h11,
        OP_MFLO  = 6'h12,
        OP_MTLO  = 6'h13,
        OP_MULT  = 6'h18,
        OP_MULTU = 6'h19,
        OP_ADD   = 6'h20,
        OP_ADDU  = 6'h21,
        OP_SUB   = 6'h22,
        OP_SUBU  = 6'h23,
        OP_AND   = 6'h24,
        OP_OR    = 6'h25,
        OP_XOR   = 6'h26,
        OP_NOR   = 6'h27,
        OP_SLT   = 6'h2a,
        OP_SLTU  = 6'h2b,
        OP_CLZ   = 6'h30, // SPECIAL2 funct collides with add, moved up
        OP_CLO   = 6'h31
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

endpackage

//--- project.f
common/mips_isa_pkg.sv
common/exec_types_pkg.sv
alu/alu_logic_shift.sv
alu/alu_arith.sv
source/hilo_unit.sv
source/ex_result_reg.sv
source/exec_stage.sv
verif/clk_gen.sv
verif/exec_stage_asserts.sv
verif/tb_exec_stage.sv

//--- source/ex_result_reg.sv
`timescale 1ns/1ns

module ex_result_reg
    import mips_isa_pkg::*, exec_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  ex_issue_t issue,
    input  word_t     logic_res,
    input  word_t     shift_res,
    input  word_t     arith_res,
    input  word_t     move_res,
    input  logic      ov_sum,
    output logic      wb_valid,
    output ex_wb_t    wb
);

    word_t  wdata_sel;
    ex_wb_t wb_next;

    always_comb begin
        case (issue.alusel)
            SEL_LOGIC: begin
                wdata_sel = logic_res;
            end
            SEL_SHIFT: begin
                wdata_sel = shift_res;
            end
            SEL_MOVE: begin
                wdata_sel = move_res;
            end
            SEL_ARITH: begin
                wdata_sel = arith_res;
            end
            default: begin
                wdata_sel = '0;
            end
        endcase
    end

    always_comb begin
        wb_next.wd    = issue.wd;
        wb_next.wdata = wdata_sel;
        wb_next.wreg  = issue.wreg && !ov_sum; // overflowed result never reaches the GPR
        wb_next.ov    = ov_sum;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb       <= '0;
        end else begin
            wb_valid <= issue_valid;
            if (issue_valid) begin
                wb <= wb_next;
            end
        end
    end

endmodule

//--- source/exec_stage.sv
`timescale 1ns/1ns

module exec_stage
    import mips_isa_pkg::*, exec_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  ex_issue_t issue,
    output logic      wb_valid,
    output ex_wb_t    wb
);

    word_t logic_res;
    word_t shift_res;
    word_t arith_res;
    word_t move_res;
    logic  ov_sum;

    alu_logic_shift u_alu_logic_shift (
        .issue     (issue),
        .logic_res (logic_res),
        .shift_res (shift_res)
    );

    alu_arith u_alu_arith (
        .issue     (issue),
        .arith_res (arith_res),
        .ov_sum    (ov_sum)
    );

    hilo_unit u_hilo_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .move_res    (move_res)
    );

    ex_result_reg u_ex_result_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .logic_res   (logic_res),
        .shift_res   (shift_res),
        .arith_res   (arith_res),
        .move_res    (move_res),
        .ov_sum      (ov_sum),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

endmodule

//--- source/hilo_unit.sv
`timescale 1ns/1ns

module hilo_unit
    import mips_isa_pkg::*, exec_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  ex_issue_t issue,
    output word_t     move_res
);

    word_t                      hi;
    word_t                      lo;
    logic                       mul_signed;
    logic signed [WORD_W:0]     mul_a;
    logic signed [WORD_W:0]     mul_b;
    logic signed [2*WORD_W+1:0] mul_full;

    // one 33x33 signed multiplier covers both mult and multu
    assign mul_signed = (issue.aluop == OP_MULT);
    assign mul_a      = {mul_signed & issue.reg1[WORD_W-1], issue.reg1};
    assign mul_b      = {mul_signed & issue.reg2[WORD_W-1], issue.reg2};
    assign mul_full   = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (issue_valid) begin
            case (issue.aluop)
                OP_MULT, OP_MULTU: begin
                    hi <= mul_full[2*WORD_W-1:WORD_W];
                    lo <= mul_full[WORD_W-1:0];
                end
                OP_MTHI: begin
                    hi <= issue.reg1;
                end
                OP_MTLO: begin
                    lo <= issue.reg1;
                end
                default: begin
                end
            endcase
        end
    end

    // reads see the registered pair, so a move right after mult gets the product
    always_comb begin
        case (issue.aluop)
            OP_MFHI: begin
                move_res = hi;
            end
            OP_MFLO: begin
                move_res = lo;
            end
            OP_MOVZ, OP_MOVN: begin
                move_res = issue.reg1;
            end
            default: begin
                move_res = '0;
            end
        endcase
    end

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

endmodule

//--- verif/exec_stage_asserts.sv
`timescale 1ns/1ns

module exec_stage_asserts
    import mips_isa_pkg::*, exec_types_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   issue_valid,
    input logic   wb_valid,
    input ex_wb_t wb
);

    int fail_count = 0; // read by the testbench at the end of the run

    a_wb_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == $past(issue_valid)) else begin
        fail_count = fail_count + 1;
        $error("wb_valid does not follow issue_valid by one cycle");
    end

    a_ov_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb.ov |-> !wb.wreg) else begin
        fail_count = fail_count + 1;
        $error("write enable set together with overflow");
    end

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid) else begin
        fail_count = fail_count + 1;
        $error("wb_valid high while in reset");
    end

endmodule

bind exec_stage exec_stage_asserts u_exec_stage_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .wb_valid    (wb_valid),
    .wb          (wb)
);

//--- verif/exec_tests.txt
# name op reg1(hex) reg2(hex) wd wreg exp_wdata(hex) exp_wreg exp_ov chain
# chain 1 issues the line on the cycle right after the previous line, with no wait
or_basic      or    f0f000ff 0ff0f00f  1 1 fff0f0ff 1 0 0
and_basic     and   f0f000ff 0ff0f00f  2 1 00f0000f 1 0 0
nor_basic     nor   f0f000ff 0ff0f00f  3 1 000f0f00 1 0 0
xor_basic     xor   f0f000ff 0ff0f00f  4 1 ff00f0f0 1 0 0
sll_by4       sll   00000004 1234abcd  5 1 234abcd0 1 0 0
srl_by8       srl   00000008 f0001234  6 1 00f00012 1 0 0
sra_negative  sra   00000004 80000010  7 1 f8000001 1 0 0
sra_low_bits  sra   00000021 fffffffe  8 1 ffffffff 1 0 0
add_small     add   00000005 00000003  9 1 00000008 1 0 0
addu_wrap     addu  ffffffff 00000002 10 1 00000001 1 0 0
sub_negative  sub   00000003 00000005 11 1 fffffffe 1 0 0
subu_wrap     subu  00000000 00000001 12 1 ffffffff 1 0 0
addi_max      addi  7ffffff0 0000000f 13 1 7fffffff 1 0 0
addiu_wrap    addiu 7fffffff 00000001 14 1 80000000 1 0 0
slt_neg_pos   slt   ffffffff 00000001 15 1 00000001 1 0 0
sltu_neg_pos  sltu  ffffffff 00000001 16 1 00000000 1 0 0
slt_pos_neg   slt   00000001 ffffffff 17 1 00000000 1 0 0
sltu_pos_neg  sltu  00000001 ffffffff 18 1 00000001 1 0 0
slt_min_max   slt   80000000 7fffffff 19 1 00000001 1 0 0
clz_zero      clz   00000000 00000000 20 1 00000020 1 0 0
clz_bit16     clz   00010000 00000000 21 1 0000000f 1 0 0
clo_ones      clo   ffffffff 00000000 22 1 00000020 1 0 0
clo_nibble    clo   f0000000 00000000 23 1 00000004 1 0 0
add_overflow  add   7fffffff 00000001 24 1 80000000 0 1 0
addu_no_trap  addu  7fffffff 00000001 24 1 80000000 1 0 0
sub_overflow  sub   80000000 00000001 25 1 7fffffff 0 1 0
mult_neg      mult  fffffffe 00000003  0 0 00000000 0 0 0
mfhi_neg      mfhi  00000000 00000000 26 1 ffffffff 1 0 0
mflo_neg      mflo  00000000 00000000 27 1 fffffffa 1 0 0
multu_big     multu fffffffe 00000003  0 0 00000000 0 0 0
mfhi_big      mfhi  00000000 00000000 28 1 00000002 1 0 0
mflo_big      mflo  00000000 00000000 28 1 fffffffa 1 0 0
mthi_load     mthi  cafe1234 00000000  0 0 00000000 0 0 0
mtlo_load     mtlo  0badf00d 00000000  0 0 00000000 0 0 0
mfhi_moved    mfhi  00000000 00000000 29 1 cafe1234 1 0 0
mflo_moved    mflo  00000000 00000000 30 1 0badf00d 1 0 0
movz_data     movz  11223344 00000000 31 1 11223344 1 0 0
movn_data     movn  55667788 00000001  1 1 55667788 1 0 0
b2b_mult      mult  ffffffff ffffffff  0 0 00000000 0 0 0
b2b_mfhi      mfhi  00000000 00000000  2 1 00000000 1 0 1
b2b_mflo      mflo  00000000 00000000  3 1 00000001 1 0 1
b2b_multu     multu ffffffff ffffffff  0 0 00000000 0 0 1
b2b_mfhi_u    mfhi  00000000 00000000  4 1 fffffffe 1 0 1
b2b_mflo_u    mflo  00000000 00000000  5 1 00000001 1 0 1
b2b_xor       xor   a5a5a5a5 ffffffff  6 1 5a5a5a5a 1 0 1
b2b_add_ov    add   80000000 80000000  7 1 00000000 0 1 1
b2b_sll       sll   0000001f 00000001  8 1 80000000 1 0 1

//--- verif/tb_exec_stage.sv
`timescale 1ns/1ns

module tb_exec_stage
    import mips_isa_pkg::*, exec_types_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20;

    typedef struct packed {
        ex_issue_t iss;
        ex_wb_t    exp;
        logic      chain; // issued on the cycle right after the previous line
    } test_vec_t;

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    ex_issue_t issue;
    logic      wb_valid;
    ex_wb_t    wb;

    test_vec_t tests[$];
    string     names[$];
    int        pending[$]; // indices of issues still waiting for write-back

    clk_gen u_clk_gen (
        .clk (clk)
    );

    exec_stage exec_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    function automatic logic find_op(input string mn, output aluop_e op);
        aluop_e e;
        e = e.first();
        op = e;
        for (int i = 0; i < e.num(); i++) begin
            if (e.name() == {"OP_", mn.toupper()}) begin
                op = e;
                return 1'b1;
            end
            e = e.next();
        end
        return 1'b0;
    endfunction

    function automatic alusel_e class_of(input aluop_e op);
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: class_of = SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA: class_of = SEL_SHIFT;
            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVZ, OP_MOVN, OP_MULT, OP_MULTU: begin
                class_of = SEL_MOVE; // hi/lo writers carry no gpr result
            end
            default: class_of = SEL_ARITH;
        endcase
    endfunction

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        string       name;
        string       mn;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] exp_data;
        int          wd;
        int          wreg;
        int          exp_wreg;
        int          exp_ov;
        int          chain;
        aluop_e      op;
        test_vec_t   tv;
        fd = $fopen("verif/exec_tests.txt", "r");
        if (fd == 0) abort_run("cannot open verif/exec_tests.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %s %h %h %d %d %h %d %d %d", name, mn, r1, r2, wd, wreg,
                          exp_data, exp_wreg, exp_ov, chain);
            if (cnt != 10) abort_run({"malformed line in test file: ", line});
            if (!find_op(mn, op)) abort_run({"unknown operation ", mn, " in test ", name});
            tv.iss.aluop  = op;
            tv.iss.alusel = class_of(op);
            tv.iss.reg1   = r1;
            tv.iss.reg2   = r2;
            tv.iss.wd     = reg_addr_t'(wd);
            tv.iss.wreg   = wreg[0];
            tv.exp.wd     = reg_addr_t'(wd);
            tv.exp.wreg   = exp_wreg[0];
            tv.exp.wdata  = exp_data;
            tv.exp.ov     = exp_ov[0];
            tv.chain      = chain[0];
            tests.push_back(tv);
            names.push_back(name);
        end
        $fclose(fd);
    endtask

    task automatic drive_issue(input int idx);
        issue       = tests[idx].iss;
        issue_valid = 1'b1;
        pending.push_back(idx);
    endtask

    task automatic check_wb();
        int idx;
        if (wb_valid) begin
            if (pending.size() == 0) abort_run("wb_valid high with no operation in flight");
            idx = pending.pop_front(); // results come back in issue order
            assert (wb.wd == tests[idx].exp.wd) else begin
                abort_run($sformatf("ERR %s wd expected %0d actual %0d",
                                    names[idx], tests[idx].exp.wd, wb.wd));
            end
            assert (wb.wreg == tests[idx].exp.wreg) else begin
                abort_run($sformatf("ERR %s wreg expected %0b actual %0b",
                                    names[idx], tests[idx].exp.wreg, wb.wreg));
            end
            assert (wb.wdata == tests[idx].exp.wdata) else begin
                abort_run($sformatf("ERR %s wdata expected %h actual %h",
                                    names[idx], tests[idx].exp.wdata, wb.wdata));
            end
            assert (wb.ov == tests[idx].exp.ov) else begin
                abort_run($sformatf("ERR %s ov expected %0b actual %0b",
                                    names[idx], tests[idx].exp.ov, wb.ov));
            end
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (pending.size() > 0) begin
            @(negedge clk);
            issue_valid = 1'b0;
            check_wb();
            waited++;
            if (pending.size() > 0 && waited >= TIMEOUT_CYCLES) begin
                abort_run("timeout while waiting for wb_valid");
            end
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        load_tests();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < tests.size(); i++) begin
            @(negedge clk);
            check_wb();
            drive_issue(i);
            if (i == tests.size() - 1 || !tests[i + 1].chain) drain_results();
        end
        if (tests.size() == 0 ||
            exec_stage_i.u_exec_stage_asserts.fail_count != 0) begin
            abort_run("no tests ran or a bound assertion failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
